//--- logic/mem_defs.svh
`default_nettype none

`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// word width in bits
`define MEM_WIDTH 32

// the low address bits pick the bank
`define MEM_NUMVBNK 8
`define MEM_BITVBNK 3

// the upper address bits pick the row inside a bank
`define MEM_NUMVROW 64
`define MEM_BITVROW 6

// cycles from a bank read strobe to its data
`define MEM_SRAM_DELAY 2

`endif

`default_nettype wire

//--- logic/mem_geom_pkg.sv
`include "mem_defs.svh"
`default_nettype none

package mem_geom_pkg;

  // a word address is the bank index below the row
  localparam int ADDR_W = `MEM_BITVBNK + `MEM_BITVROW;

  typedef logic [`MEM_WIDTH-1:0]   data_t;
  typedef logic [`MEM_BITVBNK-1:0] bank_t;
  typedef logic [`MEM_BITVROW-1:0] row_t;
  typedef logic [ADDR_W-1:0]       addr_t;

  // consecutive words land in consecutive banks
  function automatic bank_t addr_bank(addr_t adr);
    return adr[`MEM_BITVBNK-1:0];
  endfunction

  function automatic row_t addr_row(addr_t adr);
    return adr[`MEM_BITVBNK +: `MEM_BITVROW];
  endfunction

endpackage

`default_nettype wire

//--- logic/mem_cmd_pkg.sv
`default_nettype none

package mem_cmd_pkg;
  import mem_geom_pkg::*;

  // the single write waiting for its bank to go idle
  typedef struct packed {
    logic  valid;
    bank_t bank;
    row_t  row;
    data_t data;
  } wr_entry_t;

  // rides beside a read until its bank data comes back
  // fdata is only meaningful while fwrd is set
  typedef struct packed {
    logic  valid;
    bank_t bank;
    logic  fwrd;
    data_t fdata;
  } rd_tag_t;

endpackage

`default_nettype wire

//--- logic/bank_cmd_if.sv
`timescale 1ns/1ps
`default_nettype none

// command port of one single-port bank
interface bank_cmd_if import mem_geom_pkg::*; ();

  // read and write are never high in the same cycle
  logic  read;
  logic  write;
  row_t  row;
  data_t wdata;

  modport sched (
    output read,
    output write,
    output row,
    output wdata
  );

  modport ram (
    input read,
    input write,
    input row,
    input wdata
  );

endinterface

`default_nettype wire

//--- logic/bank_sched.sv
`timescale 1ns/1ps
`include "mem_defs.svh"
`default_nettype none

module bank_sched import mem_geom_pkg::*, mem_cmd_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      read,
  input  addr_t     rd_adr,
  input  logic      write,
  input  addr_t     wr_adr,
  input  data_t     din,
  bank_cmd_if.sched bank_cmd [`MEM_NUMVBNK],
  output rd_tag_t   rd_tag,
  output logic      wr_busy
);

  bank_t     rd_bank;
  row_t      rd_row;
  bank_t     wr_bank;
  row_t      wr_row;
  wr_entry_t wr_q;
  logic      rd_on_wr_bank;
  logic      wr_accept;
  logic      wr_retire;
  logic      fwd_hit;

  assign rd_bank = addr_bank(rd_adr);
  assign rd_row  = addr_row(rd_adr);
  assign wr_bank = addr_bank(wr_adr);
  assign wr_row  = addr_row(wr_adr);

  // a read owns its bank for the cycle, so the buffer has to wait
  assign rd_on_wr_bank = read && (rd_bank == wr_q.bank);

  // the buffer holds one write, and a write offered while it is full is dropped
  assign wr_accept = write && !wr_q.valid;

  // retire in any cycle the home bank is free of reads
  assign wr_retire = wr_q.valid && !rd_on_wr_bank;

  // the bank still holds the old word while the buffer is pending
  assign fwd_hit = read && wr_q.valid &&
                   (rd_bank == wr_q.bank) && (rd_row == wr_q.row);

  // an accepted write fills the buffer and a retire empties it
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_q.valid <= 1'b0;
    end else if (wr_accept) begin
      wr_q <= '{valid: 1'b1, bank: wr_bank, row: wr_row, data: din};
    end else if (wr_retire) begin
      wr_q.valid <= 1'b0;
    end
  end

  assign wr_busy = wr_q.valid;

  // the tag carries the forward data so read_return can pick it later
  assign rd_tag.valid = read;
  assign rd_tag.bank  = rd_bank;
  assign rd_tag.fwrd  = fwd_hit;
  assign rd_tag.fdata = wr_q.data;

  // per-bank strobes where a read strobe puts the read row on the bank address
  for (genvar b = 0; b < `MEM_NUMVBNK; b++) begin : g_cmd
    logic rd_sel;
    logic wr_sel;

    assign rd_sel = read && (rd_bank == bank_t'(b));
    assign wr_sel = wr_retire && (wr_q.bank == bank_t'(b));

    assign bank_cmd[b].read  = rd_sel;
    assign bank_cmd[b].write = wr_sel;
    assign bank_cmd[b].row   = rd_sel ? rd_row : wr_q.row;
    assign bank_cmd[b].wdata = wr_q.data;
  end

endmodule

`default_nettype wire

//--- logic/bank_ram.sv
`timescale 1ns/1ps
`include "mem_defs.svh"
`default_nettype none

module bank_ram import mem_geom_pkg::*; (
  input  logic    clk,
  bank_cmd_if.ram cmd,
  output data_t   dout
);

  data_t mem [`MEM_NUMVROW];

  // stage 0 holds the raw array output and the last stage drives dout
  data_t rd_pipe [`MEM_SRAM_DELAY];

  always_ff @(posedge clk) begin
    if (cmd.write) begin
      mem[cmd.row] <= cmd.wdata;
    end
  end

  // the array is only read on a strobe
  // between reads the first stage keeps its word
  always_ff @(posedge clk) begin
    if (cmd.read) begin
      rd_pipe[0] <= mem[cmd.row];
    end
  end

  // the remaining stages shift every cycle to give the fixed latency
  always_ff @(posedge clk) begin
    for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[`MEM_SRAM_DELAY-1];

endmodule

`default_nettype wire

//--- logic/read_return.sv
`timescale 1ns/1ps
`include "mem_defs.svh"
`default_nettype none

module read_return import mem_geom_pkg::*, mem_cmd_pkg::*; (
  input  logic    clk,
  input  logic    rst,
  input  rd_tag_t rd_tag,
  input  data_t   bank_dout [`MEM_NUMVBNK],
  output logic    rd_vld,
  output logic    rd_fwrd,
  output data_t   rd_dout
);

  // one tag stage per bank pipeline stage so both arrive together
  rd_tag_t tag_pipe [`MEM_SRAM_DELAY];
  rd_tag_t tag_out;
  data_t   bank_word;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MEM_SRAM_DELAY; i++) begin
        tag_pipe[i].valid <= 1'b0;
      end
    end else begin
      tag_pipe[0] <= rd_tag;
      for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
        tag_pipe[i] <= tag_pipe[i-1];
      end
    end
  end

  assign tag_out = tag_pipe[`MEM_SRAM_DELAY-1];

  // only the tagged bank was read two cycles ago
  assign bank_word = bank_dout[tag_out.bank];

  // Forwarded data is newer than anything the bank could return
  assign rd_dout = tag_out.fwrd ? tag_out.fdata : bank_word;

  assign rd_vld = tag_out.valid;

  // a forward flag only counts beside a valid tag
  assign rd_fwrd = tag_out.valid && tag_out.fwrd;

endmodule

`default_nettype wire

//--- logic/banked_mem_top.sv
`timescale 1ns/1ps
`include "mem_defs.svh"
`default_nettype none

module banked_mem_top import mem_geom_pkg::*, mem_cmd_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  read,
  input  addr_t rd_adr,
  input  logic  write,
  input  addr_t wr_adr,
  input  data_t din,
  output logic  rd_vld,
  output data_t rd_dout,
  output logic  rd_fwrd,
  output logic  wr_busy
);

  bank_cmd_if bank_cmd [`MEM_NUMVBNK] ();

  data_t   bank_dout [`MEM_NUMVBNK];
  rd_tag_t rd_tag;

  // address split, write buffer and bank arbitration
  bank_sched bank_sched_i (
    .clk      (clk),
    .rst      (rst),
    .read     (read),
    .rd_adr   (rd_adr),
    .write    (write),
    .wr_adr   (wr_adr),
    .din      (din),
    .bank_cmd (bank_cmd),
    .rd_tag   (rd_tag),
    .wr_busy  (wr_busy)
  );

  // one single-port RAM per bank
  for (genvar b = 0; b < `MEM_NUMVBNK; b++) begin : g_bank
    bank_ram bank_ram_i (
      .clk  (clk),
      .cmd  (bank_cmd[b]),
      .dout (bank_dout[b])
    );
  end

  // lines the tag up with the bank data and picks the result
  read_return read_return_i (
    .clk       (clk),
    .rst       (rst),
    .rd_tag    (rd_tag),
    .bank_dout (bank_dout),
    .rd_vld    (rd_vld),
    .rd_fwrd   (rd_fwrd),
    .rd_dout   (rd_dout)
  );

endmodule

`default_nettype wire

//--- sim/banked_mem_checker.sv
`timescale 1ns/1ps
`include "mem_defs.svh"
`default_nettype none

module banked_mem_checker import mem_geom_pkg::*; (
  input logic                    clk,
  input logic                    rst,
  input logic                    read,
  input logic                    write,
  input logic                    wr_busy,
  input row_t                    rd_row,
  input row_t                    buf_row,
  input logic                    buf_valid,
  input logic [`MEM_NUMVBNK-1:0] bank_rd,
  input logic [`MEM_NUMVBNK-1:0] bank_wr
);

  // cycles the buffered write has been waiting for its bank
  int busy_run;

  int port_errs    = 0;
  int rd_row_errs  = 0;
  int buf_row_errs = 0;
  int wr_busy_errs = 0;
  int retire_errs  = 0;
  int assert_errs;

  assign assert_errs = port_errs + rd_row_errs + buf_row_errs + wr_busy_errs + retire_errs;

  always_ff @(posedge clk) begin
    if (rst || !wr_busy) begin
      busy_run <= 0;
    end else begin
      busy_run <= busy_run + 1;
    end
  end

  // a single-port bank takes either a read or a write in one cycle
  a_bank_port: assert property (@(posedge clk) disable iff (rst)
    (bank_rd & bank_wr) == '0)
    else begin
      $error("a bank saw read and write in the same cycle");
      port_errs = port_errs + 1;
    end

  // a row that addresses a bank has to be a known value
  a_rd_row: assert property (@(posedge clk) disable iff (rst)
    read |-> !$isunknown(rd_row))
    else begin
      $error("read row is unknown");
      rd_row_errs = rd_row_errs + 1;
    end

  a_buf_row: assert property (@(posedge clk) disable iff (rst)
    buf_valid |-> !$isunknown(buf_row))
    else begin
      $error("buffered row is unknown");
      buf_row_errs = buf_row_errs + 1;
    end

  // the host has to hold off while the buffer is full
  a_wr_busy: assert property (@(posedge clk) disable iff (rst)
    write |-> !wr_busy)
    else begin
      $error("write presented while wr_busy was high");
      wr_busy_errs = wr_busy_errs + 1;
    end

  a_retire: assert property (@(posedge clk) disable iff (rst)
    busy_run <= 20)
    else begin
      $error("write buffer did not retire within 20 cycles");
      retire_errs = retire_errs + 1;
    end

endmodule

bind bank_sched banked_mem_checker banked_mem_checker_i (
  .clk       (clk),
  .rst       (rst),
  .read      (read),
  .write     (write),
  .wr_busy   (wr_busy),
  .rd_row    (rd_row),
  .buf_row   (wr_q.row),
  .buf_valid (wr_q.valid),
  .bank_rd   ({bank_cmd[7].read, bank_cmd[6].read, bank_cmd[5].read, bank_cmd[4].read,
                bank_cmd[3].read, bank_cmd[2].read, bank_cmd[1].read, bank_cmd[0].read}),
  .bank_wr   ({bank_cmd[7].write, bank_cmd[6].write, bank_cmd[5].write, bank_cmd[4].write,
                bank_cmd[3].write, bank_cmd[2].write, bank_cmd[1].write, bank_cmd[0].write})
);

`default_nettype wire

//--- sim/banked_mem_monitor.sv
`timescale 1ns/1ps
`include "mem_defs.svh"
`default_nettype none

module banked_mem_monitor import mem_geom_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         read,
  input  logic         rd_vld,
  input  data_t        rd_dout,
  input  logic         rd_fwrd,
  input  logic         wr_busy,
  input  data_t        exp_data,
  input  logic         exp_fwrd,
  input  logic [1:0]   exp_busy,
  input  logic [127:0] exp_name,
  output int           pending,
  output int           data_errs,
  output int           flag_errs,
  output int           vld_errs,
  output int           busy_errs
);

  // one entry per read strobe that still waits for its rd_vld
  int           due_q [$];
  data_t        data_q [$];
  logic         fwrd_q [$];
  logic [127:0] name_q [$];
  int           cyc_cnt;

  task automatic drop_oldest();
    due_q.delete(0);
    data_q.delete(0);
    fwrd_q.delete(0);
    name_q.delete(0);
  endtask

  always @(posedge clk) begin
    if (rst) begin
      cyc_cnt   = 0;
      data_errs = 0;
      flag_errs = 0;
      vld_errs  = 0;
      busy_errs = 0;
      due_q.delete();
      data_q.delete();
      fwrd_q.delete();
      name_q.delete();
    end else begin
      cyc_cnt = cyc_cnt + 1;

      // anything due before this cycle has missed its slot
      while (due_q.size() > 0 && due_q[0] < cyc_cnt) begin
        $display("ERROR: read %0s got no rd_vld %0d cycles after its strobe",
                 name_q[0], `MEM_SRAM_DELAY);
        vld_errs = vld_errs + 1;
        drop_oldest();
      end

      if (rd_vld) begin
        if (due_q.size() == 0 || due_q[0] != cyc_cnt) begin
          $display("ERROR: rd_vld was high with no read due in this cycle");
          vld_errs = vld_errs + 1;
        end else begin
          if (rd_dout !== data_q[0]) begin
            $display("CHECK FAILED %0s rd_dout expected %h actual %h",
                     name_q[0], data_q[0], rd_dout);
            data_errs = data_errs + 1;
          end
          if (rd_fwrd !== fwrd_q[0]) begin
            $display("CHECK FAILED %0s rd_fwrd expected %0d actual %0d",
                     name_q[0], fwrd_q[0], rd_fwrd);
            flag_errs = flag_errs + 1;
          end
          drop_oldest();
        end
      end else if (rd_fwrd !== 1'b0) begin
        $display("ERROR: rd_fwrd was high while rd_vld was low");
        flag_errs = flag_errs + 1;
      end

      // the answer belongs to the cycle the bank pipeline delivers it
      if (read) begin
        due_q.push_back(cyc_cnt + `MEM_SRAM_DELAY);
        data_q.push_back(exp_data);
        fwrd_q.push_back(exp_fwrd);
        name_q.push_back(exp_name);
      end

      // an expected level of 2 leaves wr_busy unchecked
      if (exp_busy != 2'd2 && wr_busy !== exp_busy[0]) begin
        $display("CHECK FAILED %0s wr_busy expected %0d actual %0d",
                 exp_name, exp_busy[0], wr_busy);
        busy_errs = busy_errs + 1;
      end
    end
    pending = due_q.size();
  end

endmodule

`default_nettype wire

//--- sim/banked_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

endmodule

module banked_mem_tb import mem_geom_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int BUSY_LIMIT   = 50;
  localparam int DRAIN_LIMIT  = 20;

  logic         clk;
  logic         rst;
  logic         read;
  addr_t        rd_adr;
  logic         write;
  addr_t        wr_adr;
  data_t        din;
  logic         rd_vld;
  data_t        rd_dout;
  logic         rd_fwrd;
  logic         wr_busy;

  // expectations that travel with each line's stimulus
  data_t        exp_data;
  logic         exp_fwrd;
  logic [1:0]   exp_busy;
  logic [127:0] exp_name;

  int           pending;
  int           data_errs;
  int           flag_errs;
  int           vld_errs;
  int           busy_errs;
  int           tb_errs;
  int           assert_errs;

  tb_clkgen clkgen_i (.clk (clk));

  banked_mem_top banked_mem_top_i (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .rd_adr  (rd_adr),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_fwrd (rd_fwrd),
    .wr_busy (wr_busy)
  );

  // failures of the bound assertions on the scheduler
  assign assert_errs = banked_mem_top_i.bank_sched_i.banked_mem_checker_i.assert_errs;

  banked_mem_monitor monitor_i (
    .clk       (clk),
    .rst       (rst),
    .read      (read),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout),
    .rd_fwrd   (rd_fwrd),
    .wr_busy   (wr_busy),
    .exp_data  (exp_data),
    .exp_fwrd  (exp_fwrd),
    .exp_busy  (exp_busy),
    .exp_name  (exp_name),
    .pending   (pending),
    .data_errs (data_errs),
    .flag_errs (flag_errs),
    .vld_errs  (vld_errs),
    .busy_errs (busy_errs)
  );

  initial begin : stimulus
    int           fd;
    int           code;
    int           ch;
    int           cnt;
    logic         still_busy;
    logic         done;
    logic [63:0]  op;
    logic [127:0] case_name;
    logic [31:0]  f_addr;
    logic [31:0]  f_data;
    logic [31:0]  f_fwrd;
    logic [31:0]  f_busy;

    rst      = 1'b1;
    read     = 1'b0;
    rd_adr   = '0;
    write    = 1'b0;
    wr_adr   = '0;
    din      = '0;
    exp_data = '0;
    exp_fwrd = 1'b0;
    exp_busy = 2'd2;
    exp_name = "reset";
    tb_errs  = 0;
    done     = 1'b0;

    fd = $fopen("sim/mem_cases.txt", "r");
    if (fd == 0) begin
      $display("ERROR: could not open sim/mem_cases.txt");
      tb_errs = tb_errs + 1;
    end

    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;

    while (!done && tb_errs == 0) begin
      code = $fscanf(fd, "%s", op);
      if (code != 1) begin
        done = 1'b1;
      end else if (op == "#") begin
        // a comment line is skipped to its end
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        code = $fscanf(fd, "%s %h %h %h %h", case_name, f_addr, f_data, f_fwrd, f_busy);
        if (code != 5) begin
          $display("ERROR: malformed case line after operation %0s", op);
          tb_errs = tb_errs + 1;
        end else if (op != "W" && op != "R" && op != "I" && op != "B") begin
          $display("ERROR: unknown operation %0s in case %0s", op, case_name);
          tb_errs = tb_errs + 1;
        end else begin
          @(posedge clk);
          read     <= (op == "R");
          write    <= (op == "W");
          rd_adr   <= addr_t'(f_addr);
          wr_adr   <= addr_t'(f_addr);
          din      <= f_data;
          exp_data <= f_data;
          exp_fwrd <= f_fwrd[0];
          exp_busy <= f_busy[1:0];
          exp_name <= case_name;
          if (op == "B") begin
            cnt = 0;
            do begin
              @(posedge clk);
              cnt        = cnt + 1;
              still_busy = wr_busy;
            end while (still_busy && cnt < BUSY_LIMIT);
            if (still_busy) begin
              $display("ERROR: wr_busy stayed high for %0d cycles in %0s",
                       BUSY_LIMIT, case_name);
              tb_errs = tb_errs + 1;
            end
          end
        end
      end
    end

    @(posedge clk);
    read     <= 1'b0;
    write    <= 1'b0;
    exp_busy <= 2'd2;
    exp_name <= "drain";

    // let the reads still in flight come back
    if (tb_errs == 0) begin
      cnt = 0;
      @(negedge clk);
      while (pending != 0 && cnt < DRAIN_LIMIT) begin
        @(negedge clk);
        cnt = cnt + 1;
      end
      if (pending != 0) begin
        $display("ERROR: %0d reads never returned rd_vld", pending);
        tb_errs = tb_errs + 1;
      end
    end

    // a few quiet cycles catch a stray rd_vld
    repeat (4) @(posedge clk);
    @(negedge clk);

    $display("errors: data %0d, flag %0d, valid %0d, busy %0d, assertion %0d, testbench %0d",
             data_errs, flag_errs, vld_errs, busy_errs, assert_errs, tb_errs);
    if (data_errs + flag_errs + vld_errs + busy_errs + assert_errs + tb_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+logic
logic/mem_geom_pkg.sv
logic/mem_cmd_pkg.sv
logic/bank_cmd_if.sv
logic/bank_sched.sv
logic/bank_ram.sv
logic/read_return.sv
logic/banked_mem_top.sv
sim/banked_mem_checker.sv
sim/banked_mem_monitor.sv
sim/banked_mem_tb.sv

//--- Bender.yml
package:
  name: banked_mem

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/mem_geom_pkg.sv
      - logic/mem_cmd_pkg.sv
      - logic/bank_cmd_if.sv
      - logic/bank_sched.sv
      - logic/bank_ram.sv
      - logic/read_return.sv
      - logic/banked_mem_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/banked_mem_checker.sv
      - sim/banked_mem_monitor.sv
      - sim/banked_mem_tb.sv

//--- sim/mem_cases.txt
# op name addr data fwrd busy, numbers in hex, busy 2 leaves wr_busy unchecked
# W write, R read with expected data and rd_fwrd, I idle, B wait until wr_busy is low
I idle_0 000 00000000 0 0
I idle_1 000 00000000 0 0
I idle_2 000 00000000 0 0
W wr_a 00a 1111aaaa 0 0
B wait_a 000 00000000 0 2
R rd_a 00a 1111aaaa 0 0
W wr_b 013 2222bbbb 0 0
R rd_b 013 2222bbbb 1 1
B wait_b 000 00000000 0 2
W fill_0 020 a0a0a0a0 0 0
I gap_0 000 00000000 0 1
W fill_1 021 a1a1a1a1 0 0
I gap_1 000 00000000 0 1
W fill_4 024 a4a4a4a4 0 0
I gap_4 000 00000000 0 1
W fill_5 025 a5a5a5a5 0 0
I gap_5 000 00000000 0 1
W fill_6 026 a6a6a6a6 0 0
I gap_6 000 00000000 0 1
W fill_7 027 a7a7a7a7 0 0
I gap_7 000 00000000 0 1
W wr_c 01d 5555cccc 0 0
R rd_c0 025 a5a5a5a5 0 1
R rd_c1 025 a5a5a5a5 0 1
R rd_c2 025 a5a5a5a5 0 1
I idle_c 000 00000000 0 1
R rd_c3 01d 5555cccc 0 0
R seq_0 020 a0a0a0a0 0 0
R seq_1 021 a1a1a1a1 0 0
R seq_2 00a 1111aaaa 0 0
R seq_3 013 2222bbbb 0 0
R seq_4 024 a4a4a4a4 0 0
R seq_5 025 a5a5a5a5 0 0
R seq_6 026 a6a6a6a6 0 0
R seq_7 027 a7a7a7a7 0 0
I tail_0 000 00000000 0 0
